// ==== retPred_defs.svh ====
`ifndef RETPRED_DEFS_SVH
`define RETPRED_DEFS_SVH

// Return stack and recovery queue depths
`define RET_STACK_SIZE 4
`define RET_RQ_SIZE 4

// Return-site table geometry
`define RET_PRED_SIZE 32
`define RET_PRED_ASSOC 2
`define RET_TAG_LEN 10

// Fetch sequence number width
`define FETCH_ID_W 3

// Halfword offset inside a fetch block
`define FETCH_OFF_W 2

`endif

// ==== RetPkg.sv ====
`include "retPred_defs.svh"

package RetPkg;

    // Halfword position inside one fetch block
    typedef logic [`FETCH_OFF_W-1:0] FetchOff_t;

    // Wrapping fetch sequence number, compared relative to a base
    typedef logic [`FETCH_ID_W-1:0] FetchID_t;

    typedef logic [$clog2(`RET_STACK_SIZE)-1:0] RetStackIdx_t;

    // Stack slot overwritten by a predicted return, kept for mispredict repair
    typedef struct packed {
        logic [30:0] addr;
        RetStackIdx_t idx;
        FetchID_t fetchID;
    } RetRecEntry;

    // Call/return information reported by decode
    typedef struct packed {
        logic valid;
        logic [30:0] addr;
        RetStackIdx_t idx;
        logic isCall;
        logic isRet;
        logic cleanRet;
        logic compr;
    } ReturnDecUpdate;

    // Return found in the current fetch block
    typedef struct packed {
        logic valid;
        FetchOff_t offs;
        logic compr;
    } RetHit;

endpackage

// ==== RetRecIf.sv ====
`timescale 1ns/1ps

interface RetRecIf;

    // Popped stack slot to save, one strobe per predicted return
    logic push;
    RetPkg::RetRecEntry pushEntry;

    // Saved slot to write back into the stack
    logic restore;
    RetPkg::RetRecEntry restoreEntry;

    // High while a mispredict repair is running
    logic recovering;

    modport stackSide (
        output push,
        output pushEntry,
        input restore,
        input restoreEntry,
        input recovering
    );

    modport queueSide (
        input push,
        input pushEntry,
        output restore,
        output restoreEntry,
        output recovering
    );

endinterface

// ==== RetPredTable.sv ====
`timescale 1ns/1ps
`include "retPred_defs.svh"

module RetPredTable #(
    parameter int SIZE = `RET_PRED_SIZE,
    parameter int ASSOC = `RET_PRED_ASSOC
) (
    input logic clk,
    input logic rst,
    input logic lookupValid,
    input logic [30:0] lookupPc,
    output RetPkg::RetHit hit,
    output logic [$clog2(ASSOC)-1:0] hitWay,
    input logic hitUse,
    input logic [$clog2(ASSOC)-1:0] useWay,
    input RetPkg::ReturnDecUpdate upd
);

    localparam int SETS = SIZE / ASSOC;
    localparam int SET_W = $clog2(SETS);
    localparam int WAY_W = $clog2(ASSOC);
    localparam int OFF_W = $bits(RetPkg::FetchOff_t);
    localparam int TAG_W = `RET_TAG_LEN;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        // Offset of the last halfword of the return instruction
        RetPkg::FetchOff_t offs;
        logic compr;
        logic used;
        logic valid;
    } PredEntry;

    PredEntry entries [SETS][ASSOC];

    logic [SET_W-1:0] lookupSet;
    logic [SET_W-1:0] updSet;
    logic [TAG_W-1:0] lookupTag;
    logic [TAG_W-1:0] updTag;
    RetPkg::FetchOff_t lookupOffs;
    RetPkg::FetchOff_t updOffs;
    logic [WAY_W-1:0] insWay;
    logic insValid;

    // Fold higher PC bits into the set index and the tag
    function automatic logic [SET_W-1:0] setOf(input logic [30:0] pc);
        return pc[OFF_W +: SET_W] ^ pc[OFF_W + 3 +: SET_W];
    endfunction

    function automatic logic [TAG_W-1:0] tagOf(input logic [30:0] pc);
        return pc[OFF_W +: TAG_W] ^ pc[OFF_W + TAG_W +: TAG_W];
    endfunction

    assign lookupSet = setOf(lookupPc);
    assign lookupTag = tagOf(lookupPc);
    assign lookupOffs = lookupPc[OFF_W-1:0];
    assign updSet = setOf(upd.addr);
    assign updTag = tagOf(upd.addr);
    assign updOffs = upd.addr[OFF_W-1:0];

    // First return at or after the fetch offset wins
    always_comb begin
        hit = '0;
        hitWay = '0;
        if (lookupValid) begin
            for (int i = 0; i < ASSOC; i++) begin
                if (entries[lookupSet][i].valid && entries[lookupSet][i].tag == lookupTag &&
                    entries[lookupSet][i].offs >= lookupOffs &&
                    (!hit.valid || entries[lookupSet][i].offs < hit.offs)) begin
                    hit.valid = 1'b1;
                    hit.offs = entries[lookupSet][i].offs;
                    hit.compr = entries[lookupSet][i].compr;
                    hitWay = WAY_W'(i);
                end
            end
        end
    end

    // Highest free or unused way takes a new return site
    always_comb begin
        insWay = '0;
        insValid = 1'b0;
        for (int i = 0; i < ASSOC; i++) begin
            if (!entries[updSet][i].valid || !entries[updSet][i].used) begin
                insWay = WAY_W'(i);
                insValid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < ASSOC; w++) begin
                    entries[s][w].valid <= 1'b0;
                end
            end
        end else if (upd.valid) begin
            if (upd.cleanRet) begin
                for (int w = 0; w < ASSOC; w++) begin
                    if (entries[updSet][w].tag == updTag) begin
                        entries[updSet][w].valid <= 1'b0;
                    end
                end
            end else if (upd.isRet && !upd.isCall) begin
                if (insValid) begin
                    entries[updSet][insWay].tag <= updTag;
                    entries[updSet][insWay].offs <= updOffs;
                    entries[updSet][insWay].compr <= upd.compr;
                    entries[updSet][insWay].used <= 1'b1;
                    entries[updSet][insWay].valid <= 1'b1;
                end else begin
                    // Every way recently used, age the whole set
                    for (int w = 0; w < ASSOC; w++) begin
                        entries[updSet][w].used <= 1'b0;
                    end
                end
            end
        end else if (hitUse) begin
            entries[lookupSet][useWay].used <= 1'b1;
        end
    end

endmodule

// ==== RetRecoveryQueue.sv ====
`timescale 1ns/1ps
`include "retPred_defs.svh"

module RetRecoveryQueue #(
    parameter int DEPTH = `RET_RQ_SIZE
) (
    input logic clk,
    input logic rst,
    RetRecIf.queueSide rec,
    input logic mispr,
    input RetPkg::FetchID_t misprFetchID,
    input RetPkg::FetchID_t comFetchID
);

    localparam int PTR_W = $clog2(DEPTH);

    RetPkg::RetRecEntry entries [DEPTH];

    // head is the next free slot, tail the oldest live entry
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W-1:0] newestPtr;

    RetPkg::FetchID_t comBase;
    RetPkg::FetchID_t recBase;
    RetPkg::FetchID_t recID;
    RetPkg::FetchID_t newestRel;
    RetPkg::FetchID_t recRel;
    RetPkg::FetchID_t oldestRel;
    RetPkg::FetchID_t comRel;

    logic recovering;
    logic empty;
    logic full;
    logic pushing;
    logic commitReq;
    logic retire;

    assign newestPtr = head - 1'b1;
    assign empty = head == tail;
    assign full = (head + 1'b1) == tail;

    // Fetch IDs wrap, so order them as distances from a common base
    assign newestRel = entries[newestPtr].fetchID - recBase;
    assign recRel = recID - recBase;
    assign oldestRel = entries[tail].fetchID - comBase;
    assign comRel = comFetchID - comBase;

    assign rec.restore = recovering && !mispr && !empty && newestRel >= recRel;
    assign rec.restoreEntry = entries[newestPtr];
    assign rec.recovering = recovering;

    assign pushing = rec.push && !rec.restore;
    assign commitReq = !recovering && !mispr && comBase != comFetchID;
    assign retire = commitReq && !empty && oldestRel < comRel;

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            comBase <= '0;
            recovering <= 1'b0;
        end else begin
            if (mispr) begin
                recovering <= 1'b1;
                recID <= misprFetchID;
                recBase <= comBase;
            end else if (recovering) begin
                // Unwind newest-first until an older entry shows up
                if (rec.restore) begin
                    head <= newestPtr;
                end else begin
                    recovering <= 1'b0;
                end
            end

            if (pushing) begin
                entries[head] <= rec.pushEntry;
                head <= head + 1'b1;
            end

            if (commitReq) begin
                if (retire) begin
                    comBase <= entries[tail].fetchID;
                end else begin
                    // No saved pop left in the committed range
                    comBase <= comFetchID;
                end
            end

            // A full queue drops its oldest entry on push
            if (retire || (pushing && full)) begin
                tail <= tail + 1'b1;
            end
        end
    end

endmodule

// ==== ReturnStack.sv ====
`timescale 1ns/1ps
`include "retPred_defs.svh"

module ReturnStack (
    input logic clk,
    input logic rst,
    output logic stall,
    input logic valid,
    input logic [30:0] pc,
    input logic brValid,
    input RetPkg::FetchOff_t brOffs,
    input RetPkg::FetchID_t fetchID,
    input RetPkg::FetchID_t comFetchID,
    input logic isCall,
    input logic mispr,
    input RetPkg::RetStackIdx_t misprIdx,
    input RetPkg::FetchID_t misprFetchID,
    input RetPkg::ReturnDecUpdate returnUpd,
    output RetPkg::RetStackIdx_t curIdx,
    output logic [30:0] curRetAddr,
    output RetPkg::RetHit hit,
    output logic [30:0] predDst
);

    localparam int WAY_W = $clog2(`RET_PRED_ASSOC);
    localparam int OFF_W = $bits(RetPkg::FetchOff_t);

    logic [30:0] stack [`RET_STACK_SIZE];

    RetPkg::RetStackIdx_t idxReg;
    RetPkg::RetStackIdx_t idx;
    RetPkg::RetStackIdx_t idxInc;
    RetPkg::RetStackIdx_t updIdxInc;
    logic forwardIdx;

    logic lookupValid;
    logic hitUse;
    logic [WAY_W-1:0] hitWay;

    RetRecIf recIf();

    // The mispredicted index is only known from the input, so pass it
    // straight through for the cycle after the mispredict
    assign idx = forwardIdx ? misprIdx : idxReg;
    assign idxInc = idx + 1'b1;
    assign updIdxInc = returnUpd.idx + 1'b1;

    assign curIdx = idx;
    assign curRetAddr = stack[idx];
    assign predDst = stack[idx];
    assign stall = recIf.recovering;

    assign lookupValid = valid && !mispr;

    // Return is taken unless an earlier branch leaves the block first
    assign hitUse = lookupValid && !returnUpd.valid && hit.valid &&
        (!brValid || brOffs >= hit.offs);

    // Save the slot being popped, tagged with the following fetch
    assign recIf.push = hitUse;
    assign recIf.pushEntry.addr = stack[idx];
    assign recIf.pushEntry.idx = idx;
    assign recIf.pushEntry.fetchID = fetchID + 1'b1;

    RetPredTable #(
        .SIZE(`RET_PRED_SIZE),
        .ASSOC(`RET_PRED_ASSOC)
    ) predTable (
        .clk(clk),
        .rst(rst),
        .lookupValid(lookupValid),
        .lookupPc(pc),
        .hit(hit),
        .hitWay(hitWay),
        .hitUse(hitUse),
        .useWay(hitWay),
        .upd(returnUpd)
    );

    RetRecoveryQueue #(
        .DEPTH(`RET_RQ_SIZE)
    ) recQueue (
        .clk(clk),
        .rst(rst),
        .rec(recIf.queueSide),
        .mispr(mispr),
        .misprFetchID(misprFetchID),
        .comFetchID(comFetchID)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            idxReg <= '0;
            forwardIdx <= 1'b0;
            for (int i = 0; i < `RET_STACK_SIZE; i++) begin
                stack[i] <= '0;
            end
        end else begin
            forwardIdx <= mispr;
            idxReg <= idx;

            if (recIf.restore) begin
                stack[recIf.restoreEntry.idx] <= recIf.restoreEntry.addr;
            end

            // Decode has priority over fetch-time speculation
            if (returnUpd.valid) begin
                if (!returnUpd.cleanRet && returnUpd.isCall) begin
                    stack[updIdxInc] <= returnUpd.addr + 31'd1;
                end
            end else if (lookupValid) begin
                if (hitUse) begin
                    idxReg <= idx - 1'b1;
                end else if (brValid && isCall) begin
                    // Return lands just past the call halfword
                    stack[idxInc] <= {pc[30:OFF_W], brOffs} + 31'd1;
                    idxReg <= idxInc;
                end
            end
        end
    end

endmodule

// ==== ReturnPredictor.sv ====
`timescale 1ns/1ps

module ReturnPredictor (
    input logic clk,
    input logic rst,
    output logic stall,

    // Fetch block
    input logic valid,
    input logic [30:0] pc,
    input logic brValid,
    input RetPkg::FetchOff_t brOffs,
    input RetPkg::FetchID_t fetchID,
    input RetPkg::FetchID_t comFetchID,
    input logic isCall,

    // Mispredict repair
    input logic mispr,
    input RetPkg::RetStackIdx_t misprIdx,
    input RetPkg::FetchID_t misprFetchID,

    // Decode update
    input logic updValid,
    input logic [30:0] updAddr,
    input RetPkg::RetStackIdx_t updIdx,
    input logic updIsCall,
    input logic updIsRet,
    input logic updCleanRet,
    input logic updCompr,

    output logic [30:0] curRetAddr,
    output logic [30:0] lateRetAddr,
    output RetPkg::RetStackIdx_t curIdx,
    output logic predValid,
    output RetPkg::FetchOff_t predOffs,
    output logic predCompr,
    output logic [30:0] predDst
);

    RetPkg::ReturnDecUpdate returnUpd;
    RetPkg::RetHit hit;

    assign returnUpd.valid = updValid;
    assign returnUpd.addr = updAddr;
    assign returnUpd.idx = updIdx;
    assign returnUpd.isCall = updIsCall;
    assign returnUpd.isRet = updIsRet;
    assign returnUpd.cleanRet = updCleanRet;
    assign returnUpd.compr = updCompr;

    assign predValid = hit.valid;
    assign predOffs = hit.offs;
    assign predCompr = hit.compr;

    // Returns found late in decode use the same stack top
    assign lateRetAddr = curRetAddr;

    ReturnStack retStack (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .valid(valid),
        .pc(pc),
        .brValid(brValid),
        .brOffs(brOffs),
        .fetchID(fetchID),
        .comFetchID(comFetchID),
        .isCall(isCall),
        .mispr(mispr),
        .misprIdx(misprIdx),
        .misprFetchID(misprFetchID),
        .returnUpd(returnUpd),
        .curIdx(curIdx),
        .curRetAddr(curRetAddr),
        .hit(hit),
        .predDst(predDst)
    );

endmodule

// ==== ReturnPredictor_tb.sv ====
`timescale 1ns/1ps
`include "retPred_defs.svh"

module ReturnPredictor_tb;

    localparam int CYCLES = 3000;
    localparam int STALL_LIMIT = 32;
    localparam int WAYS = `RET_PRED_ASSOC;
    localparam int SETS = `RET_PRED_SIZE / `RET_PRED_ASSOC;
    localparam int SET_W = $clog2(SETS);
    localparam int TAG_W = `RET_TAG_LEN;
    localparam int OFF_W = `FETCH_OFF_W;
    localparam int DEPTH = `RET_RQ_SIZE;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int POOL = 8;

    logic clk;
    logic rst;
    logic stall;
    logic valid;
    logic [30:0] pc;
    logic brValid;
    RetPkg::FetchOff_t brOffs;
    RetPkg::FetchID_t fetchID;
    RetPkg::FetchID_t comFetchID;
    logic isCall;
    logic mispr;
    RetPkg::RetStackIdx_t misprIdx;
    RetPkg::FetchID_t misprFetchID;
    logic updValid;
    logic [30:0] updAddr;
    RetPkg::RetStackIdx_t updIdx;
    logic updIsCall;
    logic updIsRet;
    logic updCleanRet;
    logic updCompr;
    logic [30:0] curRetAddr;
    logic [30:0] lateRetAddr;
    RetPkg::RetStackIdx_t curIdx;
    logic predValid;
    RetPkg::FetchOff_t predOffs;
    logic predCompr;
    logic [30:0] predDst;

    // Reference model state
    logic [30:0] mStack [`RET_STACK_SIZE];
    RetPkg::RetStackIdx_t mIdxReg;
    logic mFwd;
    logic [TAG_W-1:0] tTag [SETS][WAYS];
    RetPkg::FetchOff_t tOffs [SETS][WAYS];
    logic tCompr [SETS][WAYS];
    logic tUsed [SETS][WAYS];
    logic tValid [SETS][WAYS];
    RetPkg::RetRecEntry qEntry [DEPTH];
    logic [PTR_W-1:0] qHead;
    logic [PTR_W-1:0] qTail;
    RetPkg::FetchID_t comBase;
    RetPkg::FetchID_t recBase;
    RetPkg::FetchID_t recID;
    logic recovering;

    logic [30:0] pool [POOL];
    int fetchCnt;
    int comCnt;
    int cycleCount;
    int usedPreds;
    int restores;

    ReturnPredictor uut (
        .clk(clk), .rst(rst), .stall(stall),
        .valid(valid), .pc(pc), .brValid(brValid), .brOffs(brOffs),
        .fetchID(fetchID), .comFetchID(comFetchID), .isCall(isCall),
        .mispr(mispr), .misprIdx(misprIdx), .misprFetchID(misprFetchID),
        .updValid(updValid), .updAddr(updAddr), .updIdx(updIdx), .updIsCall(updIsCall),
        .updIsRet(updIsRet), .updCleanRet(updCleanRet), .updCompr(updCompr),
        .curRetAddr(curRetAddr), .lateRetAddr(lateRetAddr), .curIdx(curIdx),
        .predValid(predValid), .predOffs(predOffs), .predCompr(predCompr), .predDst(predDst)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic expectEqual(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "%s differs from the reference model", name);
        end
    endtask

    // Set index folds the field three bits higher onto the low field
    function automatic logic [SET_W-1:0] setOfPc(input logic [30:0] a);
        logic [SET_W-1:0] low;
        logic [SET_W-1:0] high;
        low = a[OFF_W +: SET_W];
        high = a[OFF_W + 3 +: SET_W];
        return low ^ high;
    endfunction

    function automatic logic [TAG_W-1:0] tagOfPc(input logic [30:0] a);
        logic [TAG_W-1:0] low;
        logic [TAG_W-1:0] high;
        low = a[OFF_W +: TAG_W];
        high = a[OFF_W + TAG_W +: TAG_W];
        return low ^ high;
    endfunction

    task automatic idleInputs();
        valid = 1'b0;
        brValid = 1'b0;
        isCall = 1'b0;
        updValid = 1'b0;
        updIsCall = 1'b0;
        updIsRet = 1'b0;
        updCleanRet = 1'b0;
    endtask

    // Compare DUT outputs with the model, then advance the model one clock
    task automatic modelCycle();
        RetPkg::RetStackIdx_t idx;
        RetPkg::RetStackIdx_t idxUp;
        RetPkg::RetStackIdx_t updUp;
        logic lookupValid;
        logic hitV;
        logic hitCompr;
        logic hitUse;
        logic restore;
        logic pushing;
        logic commitReq;
        logic retire;
        logic full;
        logic insFound;
        RetPkg::FetchOff_t hitOffs;
        int hitWay;
        int insWay;
        logic [SET_W-1:0] lSet;
        logic [SET_W-1:0] uSet;
        logic [TAG_W-1:0] lTag;
        logic [TAG_W-1:0] uTag;
        logic [PTR_W-1:0] newest;
        logic [PTR_W-1:0] headUp;
        RetPkg::FetchID_t newestRel;
        RetPkg::FetchID_t recRel;
        RetPkg::FetchID_t oldestRel;
        RetPkg::FetchID_t comRel;
        RetPkg::RetRecEntry popped;
        RetPkg::RetRecEntry restored;

        idx = mFwd ? misprIdx : mIdxReg;
        idxUp = idx + 1'b1;
        updUp = updIdx + 1'b1;
        lookupValid = valid && !mispr;
        lSet = setOfPc(pc);
        lTag = tagOfPc(pc);
        uSet = setOfPc(updAddr);
        uTag = tagOfPc(updAddr);

        // Nearest return at or after the fetch offset
        hitV = 1'b0;
        hitOffs = '0;
        hitCompr = 1'b0;
        hitWay = 0;
        if (lookupValid) begin
            for (int w = 0; w < WAYS; w++) begin
                if (tValid[lSet][w] && tTag[lSet][w] == lTag &&
                    tOffs[lSet][w] >= pc[OFF_W-1:0] && (!hitV || tOffs[lSet][w] < hitOffs)) begin
                    hitV = 1'b1;
                    hitOffs = tOffs[lSet][w];
                    hitCompr = tCompr[lSet][w];
                    hitWay = w;
                end
            end
        end
        hitUse = lookupValid && !updValid && hitV && (!brValid || brOffs >= hitOffs);

        newest = qHead - 1'b1;
        headUp = qHead + 1'b1;
        newestRel = qEntry[newest].fetchID - recBase;
        recRel = recID - recBase;
        oldestRel = qEntry[qTail].fetchID - comBase;
        comRel = comFetchID - comBase;
        restore = recovering && !mispr && qHead != qTail && newestRel >= recRel;
        pushing = hitUse && !restore;
        full = headUp == qTail;
        commitReq = !recovering && !mispr && comBase != comFetchID;
        retire = commitReq && qHead != qTail && oldestRel < comRel;
        restored = qEntry[newest];
        popped.addr = mStack[idx];
        popped.idx = idx;
        popped.fetchID = fetchID + 1'b1;

        expectEqual("stall", 32'(stall), 32'(recovering));
        expectEqual("curIdx", 32'(curIdx), 32'(idx));
        expectEqual("curRetAddr", 32'(curRetAddr), 32'(mStack[idx]));
        expectEqual("lateRetAddr", 32'(lateRetAddr), 32'(mStack[idx]));
        expectEqual("predValid", 32'(predValid), 32'(hitV));
        expectEqual("predOffs", 32'(predOffs), 32'(hitOffs));
        expectEqual("predCompr", 32'(predCompr), 32'(hitCompr));
        expectEqual("predDst", 32'(predDst), 32'(mStack[idx]));

        if (hitUse) usedPreds++;
        if (restore) restores++;

        // Stack and index, decode before fetch
        mFwd = mispr;
        mIdxReg = idx;
        if (restore) mStack[restored.idx] = restored.addr;
        if (updValid) begin
            if (!updCleanRet && updIsCall) mStack[updUp] = updAddr + 31'd1;
        end else if (lookupValid) begin
            if (hitUse) begin
                mIdxReg = idx - 1'b1;
            end else if (brValid && isCall) begin
                mStack[idxUp] = {pc[30:OFF_W], brOffs} + 31'd1;
                mIdxReg = idxUp;
            end
        end

        // Return-site table
        if (updValid) begin
            if (updCleanRet) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (tTag[uSet][w] == uTag) tValid[uSet][w] = 1'b0;
                end
            end else if (updIsRet && !updIsCall) begin
                insFound = 1'b0;
                insWay = 0;
                for (int w = 0; w < WAYS; w++) begin
                    if (!tValid[uSet][w] || !tUsed[uSet][w]) begin
                        insWay = w;
                        insFound = 1'b1;
                    end
                end
                if (insFound) begin
                    tTag[uSet][insWay] = uTag;
                    tOffs[uSet][insWay] = updAddr[OFF_W-1:0];
                    tCompr[uSet][insWay] = updCompr;
                    tUsed[uSet][insWay] = 1'b1;
                    tValid[uSet][insWay] = 1'b1;
                end else begin
                    for (int w = 0; w < WAYS; w++) tUsed[uSet][w] = 1'b0;
                end
            end
        end else if (hitUse) begin
            tUsed[lSet][hitWay] = 1'b1;
        end

        // Recovery queue
        if (commitReq) comBase = retire ? qEntry[qTail].fetchID : comFetchID;
        if (retire || (pushing && full)) qTail = qTail + 1'b1;
        if (mispr) begin
            recovering = 1'b1;
            recID = misprFetchID;
            recBase = comBase;
        end else if (recovering) begin
            if (restore) qHead = newest;
            else recovering = 1'b0;
        end
        if (pushing) begin
            qEntry[qHead] = popped;
            qHead = headUp;
        end
    endtask

    task automatic stepCycle();
        #1;
        modelCycle();
        cycleCount++;
        @(negedge clk);
    endtask

    task automatic driveRandom();
        int kind;
        valid = (fetchCnt - comCnt < 5) && ($urandom_range(0, 9) < 7);
        pc = {pool[$urandom_range(0, POOL - 1)][30:OFF_W], OFF_W'($urandom_range(0, 3))};
        brValid = $urandom_range(0, 2) == 0;
        brOffs = RetPkg::FetchOff_t'($urandom_range(0, 3));
        isCall = 1'($urandom_range(0, 1));
        fetchID = RetPkg::FetchID_t'(fetchCnt);
        if (valid) fetchCnt++;
        // Commit trails fetch by a random amount
        if (comCnt < fetchCnt && $urandom_range(0, 3) == 0) comCnt++;
        comFetchID = RetPkg::FetchID_t'(comCnt);
        kind = int'($urandom_range(0, 9));
        updValid = $urandom_range(0, 3) == 0;
        updAddr = {pool[$urandom_range(0, POOL - 1)][30:OFF_W], OFF_W'($urandom_range(0, 3))};
        updIdx = RetPkg::RetStackIdx_t'($urandom_range(0, `RET_STACK_SIZE - 1));
        updIsCall = kind < 3;
        updIsRet = kind >= 3 && kind < 9;
        updCleanRet = kind == 9;
        updCompr = 1'($urandom_range(0, 1));
    endtask

    task automatic runMispredict();
        int span;
        int target;
        int waited;
        span = fetchCnt - comCnt;
        target = comCnt + 1 + int'($urandom_range(0, span));
        idleInputs();
        mispr = 1'b1;
        misprIdx = RetPkg::RetStackIdx_t'($urandom_range(0, `RET_STACK_SIZE - 1));
        misprFetchID = RetPkg::FetchID_t'(target);
        stepCycle();
        mispr = 1'b0;
        waited = 0;
        while (stall) begin
            if (waited == STALL_LIMIT) begin
                $display("Testbench failed");
                $fatal(1, "stall stayed high too long after a mispredict");
            end
            stepCycle();
            waited++;
        end
        expectEqual("curIdx", 32'(curIdx), 32'(misprIdx));
        fetchCnt = target;
    endtask

    initial begin
        void'($urandom(32'he3f4d45b));
        rst = 1'b1;
        pc = '0;
        brOffs = '0;
        fetchID = '0;
        comFetchID = '0;
        mispr = 1'b0;
        misprIdx = '0;
        misprFetchID = '0;
        updAddr = '0;
        updIdx = '0;
        updCompr = 1'b0;
        idleInputs();

        for (int i = 0; i < `RET_STACK_SIZE; i++) mStack[i] = '0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                tTag[s][w] = '0;
                tOffs[s][w] = '0;
                tCompr[s][w] = 1'b0;
                tUsed[s][w] = 1'b0;
                tValid[s][w] = 1'b0;
            end
        end
        for (int i = 0; i < DEPTH; i++) qEntry[i] = '0;
        mIdxReg = '0;
        mFwd = 1'b0;
        qHead = '0;
        qTail = '0;
        comBase = '0;
        recBase = '0;
        recID = '0;
        recovering = 1'b0;
        fetchCnt = 0;
        comCnt = 0;
        cycleCount = 0;
        usedPreds = 0;
        restores = 0;

        // Two sets with four sites each, so ways get replaced
        for (int i = 0; i < POOL; i++) begin
            pool[i] = (31'($urandom()) & 31'h7FFF_FE00) | ((i % 2 == 1) ? 31'h54 : 31'h0);
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Fresh state predicts nothing
        valid = 1'b1;
        pc = pool[0];
        #1;
        expectEqual("stall", 32'(stall), 32'd0);
        expectEqual("predValid", 32'(predValid), 32'd0);
        expectEqual("curIdx", 32'(curIdx), 32'd0);
        fetchCnt = 1;
        modelCycle();
        cycleCount++;
        @(negedge clk);

        while (cycleCount < CYCLES) begin
            if (fetchCnt > comCnt && $urandom_range(0, 39) == 0) begin
                runMispredict();
            end else begin
                driveRandom();
                stepCycle();
            end
        end

        if (usedPreds == 0 || restores == 0) begin
            $display("Testbench failed");
            $fatal(1, "random stimulus never used a prediction or restored an entry");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
+incdir+.
RetPkg.sv
RetRecIf.sv
RetPredTable.sv
RetRecoveryQueue.sv
ReturnStack.sv
ReturnPredictor.sv
ReturnPredictor_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the return predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module ReturnPredictor_tb -f tb.f -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/simv
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
